/* filelist.f */
hw/dtsPkg.sv
hw/markGen.sv
hw/barrelShift.sv
hw/candidateEval.sv
hw/dtsState.sv
hw/searchCtrl.sv
hw/dtsWorker.sv
dv/dtsWorkerTb.sv

/* dv/dtsStim.txt */
// words in hex: run count, then marks per block with the zero mark
// then one hold time in cycles per run, spent in done before anotherOne
3
4
5
14
1

/* dv/dtsWorkerTb.sv */
//**************************************************
// self-checking testbench for the search worker
// checks each found set against the DTS rules
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module dtsWorkerTb;

	localparam int STIM_WORDS = 5; // run count, marks, three hold times
	localparam int CYCLES_PER_RUN = 200000;

	logic clk;
	logic reset;
	logic anotherOne;
	dtsPkg::blockSetT natRuler;
	logic done;

	logic [31:0] stim [STIM_WORDS];
	int errors = 0;
	int checks = 0;
	int watchLimit = 0;

	dtsWorker dtsWorker_i (
		.clk(clk), .reset(reset), .anotherOne(anotherOne),
		.natRuler(natRuler), .done(done)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	function automatic int countMarks(input dtsPkg::rulerT r);
		int n;
		n = 0;
		for (int m = 0; m <= dtsPkg::MAX_MARK; m++) begin
			n += r[m];
		end
		return n;
	endfunction

	// zero mark, mark count, every difference used once over the whole set
	task automatic checkSet(input dtsPkg::blockSetT blocks, input int marksPerBlock);
		logic [dtsPkg::MAX_MARK:0] seen;
		int repeats;
		int d;
		seen = '0;
		repeats = 0;
		for (int b = 0; b < dtsPkg::NUM_BLOCKS; b++) begin
			compare($sformatf("natRuler[%0d][0]", b), blocks[b][0], 1'b1);
			compare($sformatf("marks in natRuler[%0d]", b), countMarks(blocks[b]), marksPerBlock);
			// the ruler width keeps every difference within MAX_MARK
			for (int lo = 0; lo <= dtsPkg::MAX_MARK; lo++) begin
				for (int hi = lo + 1; hi <= dtsPkg::MAX_MARK; hi++) begin
					if (blocks[b][lo] && blocks[b][hi]) begin
						d = hi - lo;
						if (seen[d]) repeats++;
						seen[d] = 1'b1;
					end
				end
			end
		end
		compare("repeated differences", repeats, 0);
	endtask

	initial begin
		int runs;
		int marksPerBlock;
		int holdSum;
		dtsPkg::blockSetT held;
		reset = 1'b1;
		anotherOne = 1'b0;
		$readmemh("dv/dtsStim.txt", stim);
		runs = stim[0];
		marksPerBlock = stim[1];
		if (runs < 1 || runs > STIM_WORDS - 2) begin
			$display("stim file asks for %0d runs but holds hold times for %0d", runs,
				STIM_WORDS - 2);
			errors++;
			runs = STIM_WORDS - 2;
		end
		holdSum = 0;
		for (int r = 0; r < runs; r++) holdSum += stim[2 + r];
		watchLimit = runs * CYCLES_PER_RUN + holdSum + 20 + 4 * runs; // reset and handshakes

		repeat (9) begin
			@(negedge clk);
			compare("done", done, 1'b0); // low through reset
		end
		@(posedge clk);
		reset <= 1'b0;
		repeat (2) begin
			@(negedge clk);
			compare("done", done, 1'b0);
		end

		for (int r = 0; r < runs; r++) begin
			while (!done) @(negedge clk); // bounded by the watchdog
			held = natRuler;
			checkSet(natRuler, marksPerBlock);
			for (int c = 0; c < stim[2 + r]; c++) begin
				@(negedge clk);
				compare("done", done, 1'b1);
				compare("natRuler", natRuler, held);
			end
			@(posedge clk);
			anotherOne <= 1'b1;
			@(negedge clk);
			compare("done", done, 1'b1); // not sampled yet
			@(posedge clk);
			anotherOne <= 1'b0;
			@(negedge clk);
			compare("done", done, 1'b0);
		end

		$display("%0d errors in %0d checks", errors, checks);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// ends a search that never reaches done
	initial begin
		wait (watchLimit > 0);
		repeat (watchLimit) @(posedge clk);
		$display("watchdog expired after %0d cycles, no set was found in time", watchLimit);
		$display("%0d errors in %0d checks", errors, checks);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* hw/dtsWorker.sv */
//**************************************************
// difference triangle set search worker
// generator, candidate pipeline, FSM and store
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module dtsWorker #(
	parameter logic [31:0] SEED = 32'h2545f491,
	parameter int BLOCK_THRESH = 64,
	parameter int SET_THRESH = 256
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic anotherOne,
	output dtsPkg::blockSetT natRuler,
	output logic done
);

	dtsPkg::markT mark;
	dtsPkg::candT active, cand;
	dtsPkg::blockCountT blockCount;
	logic markValid, candFits, flush, clearSet, insert, ready;

	markGen #(.SEED(SEED)) markGen_i (
		.clk(clk), .reset(reset), .mark(mark), .markValid(markValid)
	);

	candidateEval candidateEval_i (
		.clk(clk), .flush(flush), .mark(mark), .markValid(markValid),
		.active(active), .cand(cand), .candFits(candFits)
	);

	searchCtrl #(.BLOCK_THRESH(BLOCK_THRESH), .SET_THRESH(SET_THRESH)) searchCtrl_i (
		.clk(clk), .reset(reset), .candFits(candFits), .cand(cand), .ready(ready),
		.blockCount(blockCount), .anotherOne(anotherOne), .active(active),
		.flush(flush), .clearSet(clearSet), .insert(insert), .done(done)
	);

	dtsState dtsState_i (
		.clk(clk), .clearSet(clearSet), .insert(insert), .natRulerIn(active.natRuler),
		.natRuler(natRuler), .blockCount(blockCount), .ready(ready)
	);

endmodule

`default_nettype wire

/* hw/searchCtrl.sv */
//**************************************************
// search FSM: active block, mark count,
// block and set iteration counters, store control
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module searchCtrl #(
	parameter int BLOCK_THRESH = 64,
	parameter int SET_THRESH = 256
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic candFits,
	input wire dtsPkg::candT cand,
	input wire logic ready,
	input wire dtsPkg::blockCountT blockCount,
	input wire logic anotherOne,
	output dtsPkg::candT active,
	output logic flush,
	output logic clearSet,
	output logic insert,
	output logic done
);

	localparam int BLOCK_W = $clog2(BLOCK_THRESH + 1);
	localparam int SET_W = $clog2(SET_THRESH + 1);
	localparam int J_W = $clog2(dtsPkg::NUM_MARKS + 1);

	dtsPkg::ctrlStateT state;
	dtsPkg::rulerT blockStartCum; // set spectrum before this block
	logic [J_W-1:0] j;            // marks placed in this block
	logic [BLOCK_W-1:0] blockIters;
	logic [SET_W-1:0] setIters;

	logic startBlock, blockOut, setOut, accept, lastMark, lastBlock;

	// empty block on top of the given set spectrum
	function automatic dtsPkg::candT freshBlock(input dtsPkg::rulerT cum);
		dtsPkg::candT c;
		c.natRuler = dtsPkg::rulerT'(1); // only the zero mark
		c.revRuler = dtsPkg::rulerT'(1);
		c.spectrum = '0;
		c.cumSpectrum = cum;
		c.largestMark = '0;
		return c;
	endfunction

	assign startBlock = (state == dtsPkg::waitBlock) && ready && !clearSet;
	assign blockOut = (state == dtsPkg::build) && (blockIters == BLOCK_W'(BLOCK_THRESH));
	assign setOut = blockOut && (setIters >= SET_W'(SET_THRESH - 1));
	// verdicts seen while flush is up belong to the old block state
	assign accept = (state == dtsPkg::build) && !blockOut && candFits && !flush;
	assign lastMark = (j == J_W'(dtsPkg::NUM_MARKS - 1));
	assign lastBlock = (blockCount == dtsPkg::blockCountT'(dtsPkg::NUM_BLOCKS - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= dtsPkg::resetSet;
			flush <= 1'b0;
			clearSet <= 1'b0;
			insert <= 1'b0;
			done <= 1'b0;
		end else begin
			flush <= 1'b0;
			clearSet <= 1'b0;
			insert <= 1'b0;
			case (state)
				dtsPkg::resetSet: begin
					clearSet <= 1'b1;
					flush <= 1'b1;
					state <= dtsPkg::waitBlock;
				end
				dtsPkg::waitBlock: begin
					if (startBlock) begin
						flush <= 1'b1; // new block state
						state <= dtsPkg::build;
					end
				end
				dtsPkg::build: begin
					if (setOut) begin
						state <= dtsPkg::resetSet;
					end else if (blockOut) begin
						flush <= 1'b1; // retry the same block
					end else if (accept) begin
						flush <= 1'b1;
						if (lastMark) begin
							insert <= 1'b1; // store sees the finished ruler next cycle
							state <= lastBlock ? dtsPkg::finishSet : dtsPkg::insertBlock;
						end
					end
				end
				dtsPkg::insertBlock: state <= dtsPkg::waitBlock;
				dtsPkg::finishSet: begin
					done <= 1'b1; // last ruler lands in the store on this edge
					state <= dtsPkg::holdDone;
				end
				dtsPkg::holdDone: begin
					if (anotherOne) begin
						done <= 1'b0;
						state <= dtsPkg::resetSet;
					end
				end
				default: state <= dtsPkg::resetSet;
			endcase
		end
	end

	// block registers and counters
	always_ff @(posedge clk) begin
		case (state)
			dtsPkg::resetSet: begin
				active <= freshBlock('0);
				blockStartCum <= '0;
				j <= '0;
				blockIters <= '0;
				setIters <= '0;
			end
			dtsPkg::waitBlock: begin
				if (startBlock) begin
					active <= freshBlock(active.cumSpectrum);
					blockStartCum <= active.cumSpectrum;
					j <= '0;
					blockIters <= '0;
				end
			end
			dtsPkg::build: begin
				if (blockOut) begin
					active <= freshBlock(blockStartCum); // drop only this block
					j <= '0;
					blockIters <= '0;
					setIters <= setIters + SET_W'(1);
				end else begin
					blockIters <= blockIters + BLOCK_W'(1);
					if (accept) begin
						active <= cand;
						j <= j + J_W'(1);
					end
				end
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* hw/dtsState.sv */
//**************************************************
// store of completed block rulers
// write count and ready flag
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module dtsState (
	input wire logic clk,
	input wire logic clearSet,
	input wire logic insert,
	input wire dtsPkg::rulerT natRulerIn,
	output dtsPkg::blockSetT natRuler,
	output dtsPkg::blockCountT blockCount,
	output logic ready
);

	// busy for one cycle after any write
	always_ff @(posedge clk) begin
		ready <= !(clearSet || insert);
	end

	always_ff @(posedge clk) begin
		if (clearSet) begin
			blockCount <= '0;
		end else if (insert) begin
			blockCount <= blockCount + dtsPkg::blockCountT'(1);
		end
	end

	// block rulers, slot picked by the count
	always_ff @(posedge clk) begin
		if (insert && !clearSet) begin
			natRuler[blockCount] <= natRulerIn;
		end
	end

	noOverfill: assert property (@(posedge clk)
		insert |-> blockCount < dtsPkg::NUM_BLOCKS);

endmodule

`default_nettype wire

/* hw/candidateEval.sv */
//**************************************************
// candidate pipeline: builds the new rulers and
// spectra for one mark and judges whether it fits
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module candidateEval (
	input wire logic clk,
	input wire logic flush,
	input wire dtsPkg::markT mark,
	input wire logic markValid,
	input wire dtsPkg::candT active,
	output dtsPkg::candT cand,
	output logic candFits
);

	localparam int SL = dtsPkg::SHIFT_LATENCY;

	// stage 1
	dtsPkg::markT markQ;
	dtsPkg::markT upQ;   // mark above the largest mark
	dtsPkg::markT downQ; // mark below the largest mark
	logic extQ;
	logic validQ;

	always_ff @(posedge clk) begin
		validQ <= flush ? 1'b0 : markValid;
		markQ <= mark;
		upQ <= mark - active.largestMark;
		downQ <= active.largestMark - mark;
		extQ <= mark > active.largestMark;
	end

	// distances from the mark to the existing marks
	dtsPkg::rulerT extDist;  // ruler is extended
	dtsPkg::rulerT lowDist;  // marks below the new one
	dtsPkg::rulerT highDist; // marks above the new one
	logic extValid;
	logic lowValid;
	logic highValid;
	logic shiftValid;

	barrelShift #(.LEFT(1'b1)) extShift_i (
		.clk(clk), .flush(flush), .in(active.revRuler), .shift(upQ),
		.validIn(validQ), .out(extDist), .validOut(extValid)
	);

	barrelShift #(.LEFT(1'b0)) lowShift_i (
		.clk(clk), .flush(flush), .in(active.revRuler), .shift(downQ),
		.validIn(validQ), .out(lowDist), .validOut(lowValid)
	);

	barrelShift #(.LEFT(1'b0)) highShift_i (
		.clk(clk), .flush(flush), .in(active.natRuler), .shift(markQ),
		.validIn(validQ), .out(highDist), .validOut(highValid)
	);

	assign shiftValid = extValid & lowValid & highValid;

	// mark side data follows the shifters
	dtsPkg::markT markPipe [SL];
	dtsPkg::markT downPipe [SL];
	logic [SL-1:0] extPipe;

	always_ff @(posedge clk) begin
		markPipe[0] <= markQ;
		downPipe[0] <= downQ;
		extPipe[0] <= extQ;
		for (int s = 1; s < SL; s++) begin
			markPipe[s] <= markPipe[s-1];
			downPipe[s] <= downPipe[s-1];
			extPipe[s] <= extPipe[s-1];
		end
	end

	// stage 5: distance set, intersection, bisection
	dtsPkg::rulerT dist5, inter5, bisect5, natRuler5, revRuler5;
	dtsPkg::markT mark5, largest5;
	logic present5, valid5;

	always_ff @(posedge clk) begin
		valid5 <= flush ? 1'b0 : shiftValid;
		dist5 <= extPipe[SL-1] ? extDist : (lowDist | highDist);
		inter5 <= active.cumSpectrum & (extPipe[SL-1] ? extDist : (lowDist | highDist));
		bisect5 <= extPipe[SL-1] ? '0 : (lowDist & highDist); // equidistant marks
		natRuler5 <= active.natRuler | (dtsPkg::rulerT'(1) << markPipe[SL-1]);
		revRuler5 <= extPipe[SL-1] ? (extDist | dtsPkg::rulerT'(1)) :
			(active.revRuler | (dtsPkg::rulerT'(1) << downPipe[SL-1]));
		largest5 <= extPipe[SL-1] ? markPipe[SL-1] : active.largestMark;
		present5 <= active.natRuler[markPipe[SL-1]];
		mark5 <= markPipe[SL-1];
	end

	// stage 6: reductions and new spectra
	dtsPkg::rulerT natRuler6, revRuler6, spectrum6, cum6;
	dtsPkg::markT largest6;
	logic interAny6, bisectAny6, ok6, valid6;

	always_ff @(posedge clk) begin
		valid6 <= flush ? 1'b0 : valid5;
		interAny6 <= |inter5;
		bisectAny6 <= |bisect5;
		// distance to zero is the largest, if it is there nothing fell off
		ok6 <= !present5 && dist5[mark5];
		spectrum6 <= active.spectrum | dist5;
		cum6 <= active.cumSpectrum | dist5;
		natRuler6 <= natRuler5;
		revRuler6 <= revRuler5;
		largest6 <= largest5;
	end

	// stage 7: verdict
	always_ff @(posedge clk) begin
		candFits <= flush ? 1'b0 : (valid6 && ok6 && !interAny6 && !bisectAny6);
		cand.natRuler <= natRuler6;
		cand.revRuler <= revRuler6;
		cand.spectrum <= spectrum6;
		cand.cumSpectrum <= cum6;
		cand.largestMark <= largest6;
	end

	// nothing from before a flush may come out the far end
	noStaleFit: assert property (@(posedge clk)
		flush |=> !candFits [*dtsPkg::CAND_LATENCY]);

endmodule

`default_nettype wire

/* hw/barrelShift.sv */
//**************************************************
// pipelined log shifter for ruler bit sets
// one register after every two shift levels
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module barrelShift #(
	parameter bit LEFT = 1'b1 // 0 shifts right
) (
	input wire logic clk,
	input wire logic flush,
	input wire dtsPkg::rulerT in,
	input wire dtsPkg::markT shift,
	input wire logic validIn,
	output dtsPkg::rulerT out,
	output logic validOut
);

	localparam int STAGES = dtsPkg::SHIFT_LATENCY;

	wire dtsPkg::rulerT stageData [STAGES+1];
	wire dtsPkg::markT stageShift [STAGES+1];
	wire [STAGES:0] stageValid;

	assign stageData[0] = in;
	assign stageShift[0] = shift;
	assign stageValid[0] = validIn;

	for (genvar s = 0; s < STAGES; s++) begin : level
		dtsPkg::rulerT shifted;
		dtsPkg::rulerT dataQ;
		dtsPkg::markT shiftQ;
		logic validQ;

		// levels 2s and 2s+1, the last stage may hold only one
		always_comb begin
			shifted = stageData[s];
			for (int l = 2 * s; l < 2 * s + 2; l++) begin
				if (l < dtsPkg::MARK_W) begin
					if (stageShift[s][l]) begin
						shifted = LEFT ? (shifted << (1 << l)) : (shifted >> (1 << l));
					end
				end
			end
		end

		always_ff @(posedge clk) begin
			dataQ <= shifted;
			shiftQ <= stageShift[s];
			validQ <= flush ? 1'b0 : stageValid[s];
		end

		assign stageData[s+1] = dataQ;
		assign stageShift[s+1] = shiftQ;
		assign stageValid[s+1] = validQ;
	end

	assign out = stageData[STAGES];
	assign validOut = stageValid[STAGES];

endmodule

`default_nettype wire

/* hw/markGen.sv */
//**************************************************
// xorshift mark source, one mark in 1..MAX_MARK
// per cycle, never stalled
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module markGen #(
	parameter logic [31:0] SEED = 32'h2545f491 // must be nonzero
) (
	input wire logic clk,
	input wire logic reset,
	output dtsPkg::markT mark,
	output logic markValid
);

	logic [31:0] xs;
	logic [31:0] xsNext;

	// classic 13/17/5 xorshift step
	always_comb begin
		xsNext = xs ^ (xs << 13);
		xsNext = xsNext ^ (xsNext >> 17);
		xsNext = xsNext ^ (xsNext << 5);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			xs <= SEED;
			markValid <= 1'b0;
		end else begin
			xs <= xsNext;
			markValid <= 1'b1; // first mark after one step
		end
	end

	// fold into 0..MAX_MARK-1 and skip zero
	always_ff @(posedge clk) begin
		mark <= dtsPkg::markT'(xs % 32'(dtsPkg::MAX_MARK)) + dtsPkg::markT'(1);
	end

	markRange: assert property (@(posedge clk) disable iff (reset)
		markValid |-> (mark != '0) && (mark <= dtsPkg::MAX_MARK));

endmodule

`default_nettype wire

/* hw/dtsPkg.sv */
//**************************************************
// shared sizes, ruler and candidate types and the
// controller state encoding for the search worker
//**************************************************
`default_nettype none

package dtsPkg;

	// set geometry
	localparam int NUM_BLOCKS = 2;
	localparam int NUM_MARKS = 3; // zero mark not counted
	localparam int MAX_MARK = 19;

	localparam int MARK_W = $clog2(MAX_MARK + 1);

	// one register per two shift levels
	localparam int SHIFT_LATENCY = (MARK_W + 1) / 2;
	// mark register, shifter, then three judging stages
	localparam int CAND_LATENCY = 1 + SHIFT_LATENCY + 3;

	typedef logic [MARK_W-1:0] markT;

	// bit m is mark m in a ruler, distance m in a spectrum
	typedef logic [MAX_MARK:0] rulerT;

	typedef rulerT [NUM_BLOCKS-1:0] blockSetT;

	typedef logic [$clog2(NUM_BLOCKS + 1)-1:0] blockCountT;

	typedef struct packed {
		rulerT natRuler;    // marks seen from zero
		rulerT revRuler;    // marks seen from the largest mark
		rulerT spectrum;    // differences of this block
		rulerT cumSpectrum; // differences of the whole set so far
		markT largestMark;
	} candT;

	typedef enum logic [2:0] {
		resetSet,
		waitBlock,
		build,
		insertBlock,
		finishSet,
		holdDone
	} ctrlStateT;

endpackage

`default_nettype wire
